// File: logic/bicubic_pkg.sv
package bicubic_pkg;

    // source frame and 2x output frame
    localparam int IMG_W   = 6;
    localparam int IMG_H   = 4;
    localparam int OUT_W   = 2 * IMG_W;
    localparam int OUT_H   = 2 * IMG_H;
    localparam int SRC_PIX = IMG_W * IMG_H;

    // pixel is {red, green, blue}, blue in the low byte as stored in a BMP
    localparam int PIX_W  = 24;
    localparam int CH_W   = 8;
    localparam int H_W    = 16;
    localparam int V_W    = 24;
    localparam int W_FRAC = 6;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1);

    localparam int ADDR_W = $clog2(SRC_PIX);
    localparam int COL_W  = $clog2(IMG_W);
    localparam int ROW_W  = $clog2(IMG_H);
    localparam int OX_W   = $clog2(OUT_W);
    localparam int OY_W   = $clog2(OUT_H);

    typedef logic [PIX_W-1:0]         pixel_t;
    typedef logic signed [7:0]        coef_t;
    typedef logic signed [CH_W:0]     h_sample_t;
    typedef logic signed [H_W-1:0]    v_sample_t;
    typedef logic signed [V_W-1:0]    v_acc_t;
    typedef logic [ADDR_W-1:0]        src_addr_t;
    typedef logic [COL_W-1:0]         col_t;
    typedef logic [ROW_W-1:0]         row_t;
    typedef logic [1:0]               tap_idx_t;
    typedef logic [LVL_W-1:0]         level_t;

    // bicubic a = -0.5 sampled at phase 0 and phase 1/2, in 1/64 units
    localparam coef_t WEIGHTS [2][4] = '{'{0, 64, 0, 0}, '{-4, 36, 36, -4}};

    typedef struct packed {
        pixel_t data;
        logic   last;
    } out_beat_t;

endpackage

// File: logic/bicubic_frame_buffer.sv
`timescale 1ns/1ps

module bicubic_frame_buffer
    import bicubic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  src_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  logic      rd_en,
    input  row_t      rd_row,
    input  col_t      rd_col,
    output pixel_t    rd_pix0,
    output pixel_t    rd_pix1,
    output pixel_t    rd_pix2,
    output pixel_t    rd_pix3
);

    pixel_t mem [SRC_PIX];

    // edge replication for the horizontal taps
    function automatic col_t clamp_col(input int c);
        if (c < 0) begin
            return '0;
        end
        if (c > IMG_W - 1) begin
            return col_t'(IMG_W - 1);
        end
        return col_t'(c);
    endfunction

    function automatic src_addr_t pix_addr(input row_t r, input col_t c);
        return src_addr_t'(int'(r) * IMG_W + int'(c));
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // window of columns rd_col-1 .. rd_col+2 on the requested row
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_pix0 <= mem[pix_addr(rd_row, clamp_col(int'(rd_col) - 1))];
            rd_pix1 <= mem[pix_addr(rd_row, rd_col)];
            rd_pix2 <= mem[pix_addr(rd_row, clamp_col(int'(rd_col) + 1))];
            rd_pix3 <= mem[pix_addr(rd_row, clamp_col(int'(rd_col) + 2))];
        end
    end

    // single ported in practice, loading and scaling never overlap
    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en)
    );

endmodule

// File: logic/bicubic_addr_gen.sv
`timescale 1ns/1ps

module bicubic_addr_gen
    import bicubic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  level_t    level,
    output logic      in_ready,
    output logic      wr_en,
    output src_addr_t wr_addr,
    output logic      rd_en,
    output row_t      rd_row,
    output col_t      rd_col,
    output logic      tap_valid,
    output tap_idx_t  tap_idx,
    output logic      h_phase,
    output logic      v_phase,
    output logic      tap_last
);

    typedef enum logic {ST_LOAD, ST_SCALE} state_t;

    state_t          state;
    src_addr_t       load_cnt;
    logic [OX_W-1:0] ox;
    logic [OY_W-1:0] oy;
    tap_idx_t        tap_cnt;
    level_t          in_flight;
    logic            all_issued;
    logic            space_ok;
    logic            last_pix;
    logic            start_pix;
    logic            issue_last_tap;
    logic [1:0]      done_pipe;
    int              row_tap;

    assign in_ready = (state == ST_LOAD);
    assign wr_en    = in_valid && in_ready;
    assign wr_addr  = load_cnt;

    // a pixel only starts when the FIFO has room for it and all pixels ahead
    assign space_ok  = (int'(level) + int'(in_flight)) < FIFO_DEPTH;
    assign rd_en     = (state == ST_SCALE) && !all_issued && ((tap_cnt != '0) || space_ok);
    assign start_pix = rd_en && (tap_cnt == 2'd0);
    assign last_pix  = (ox == OX_W'(OUT_W - 1)) && (oy == OY_W'(OUT_H - 1));
    assign issue_last_tap = rd_en && (tap_cnt == 2'd3);

    assign rd_col = col_t'(ox >> 1);

    // row tap sy-1+tap_cnt, clamped to the frame
    always_comb begin
        row_tap = int'(oy >> 1) - 1 + int'(tap_cnt);
        if (row_tap < 0) begin
            rd_row = '0;
        end else if (row_tap > IMG_H - 1) begin
            rd_row = row_t'(IMG_H - 1);
        end else begin
            rd_row = row_t'(row_tap);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_LOAD;
            load_cnt   <= '0;
            ox         <= '0;
            oy         <= '0;
            tap_cnt    <= '0;
            all_issued <= 1'b0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (wr_en) begin
                        if (load_cnt == src_addr_t'(SRC_PIX - 1)) begin
                            load_cnt <= '0;
                            state    <= ST_SCALE;
                        end else begin
                            load_cnt <= load_cnt + 1'b1;
                        end
                    end
                end
                ST_SCALE: begin
                    if (rd_en) begin
                        tap_cnt <= tap_cnt + 1'b1;
                        if (tap_cnt == 2'd3) begin
                            if (last_pix) begin
                                all_issued <= 1'b1;
                            end else if (ox == OX_W'(OUT_W - 1)) begin
                                ox <= '0;
                                oy <= oy + 1'b1;
                            end else begin
                                ox <= ox + 1'b1;
                            end
                        end
                    end
                    // wait for the kernel and the FIFO to empty before the next load
                    if (all_issued && (in_flight == '0) && (level == '0)) begin
                        state      <= ST_LOAD;
                        all_issued <= 1'b0;
                        ox         <= '0;
                        oy         <= '0;
                    end
                end
                default: state <= ST_LOAD;
            endcase
        end
    end

    // pixel leaves in_flight on the cycle the kernel pushes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
            done_pipe <= '0;
        end else begin
            done_pipe <= {done_pipe[0], issue_last_tap};
            case ({start_pix, done_pipe[1]})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // tap controls follow the one cycle buffer read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_valid <= 1'b0;
            tap_idx   <= '0;
            h_phase   <= 1'b0;
            v_phase   <= 1'b0;
            tap_last  <= 1'b0;
        end else begin
            tap_valid <= rd_en;
            tap_idx   <= tap_cnt;
            h_phase   <= ox[0];
            v_phase   <= oy[0];
            tap_last  <= last_pix;
        end
    end

    a_tap_seq: assert property (
        @(posedge clk) disable iff (!rst_n)
        tap_valid && (tap_idx != 2'd3) |=> tap_valid && (tap_idx == $past(tap_idx) + 2'd1)
    );

    // every started pixel already owns a FIFO slot
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int'(level) + int'(in_flight)) <= FIFO_DEPTH
    );

endmodule

// File: logic/bicubic_tap_filter.sv
`timescale 1ns/1ps

module bicubic_tap_filter
    import bicubic_pkg::*;
#(
    parameter type sample_t = h_sample_t,
    parameter type acc_t    = v_sample_t
) (
    input  sample_t s0,
    input  sample_t s1,
    input  sample_t s2,
    input  sample_t s3,
    input  logic    phase,
    output acc_t    acc
);

    acc_t p0;
    acc_t p1;
    acc_t p2;
    acc_t p3;

    // samples and weights are sign extended to the accumulator width first
    always_comb begin
        p0  = acc_t'(s0) * acc_t'(WEIGHTS[phase][0]);
        p1  = acc_t'(s1) * acc_t'(WEIGHTS[phase][1]);
        p2  = acc_t'(s2) * acc_t'(WEIGHTS[phase][2]);
        p3  = acc_t'(s3) * acc_t'(WEIGHTS[phase][3]);
        acc = p0 + p1 + p2 + p3;
    end

endmodule

// File: logic/bicubic_kernel.sv
`timescale 1ns/1ps

module bicubic_kernel
    import bicubic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tap_valid,
    input  tap_idx_t  tap_idx,
    input  logic      h_phase,
    input  logic      v_phase,
    input  logic      tap_last,
    input  pixel_t    pix0,
    input  pixel_t    pix1,
    input  pixel_t    pix2,
    input  pixel_t    pix3,
    output logic      push,
    output out_beat_t push_beat
);

    v_sample_t       h_cur  [3];
    v_sample_t       h_hold [3][3];
    v_acc_t          v_sum  [3];
    logic [CH_W-1:0] ch_out [3];
    logic            final_tap;

    // both passes carry 2*W_FRAC fraction bits, round to nearest then saturate
    function automatic logic [CH_W-1:0] round_clamp(input v_acc_t v);
        v_acc_t r;
        r = (v + v_acc_t'(1 << (2 * W_FRAC - 1))) >>> (2 * W_FRAC);
        if (r < 0) begin
            return '0;
        end
        if (r > 255) begin
            return '1;
        end
        return r[CH_W-1:0];
    endfunction

    assign final_tap = tap_valid && (tap_idx == 2'd3);

    // channel 0 is blue, the low byte
    for (genvar ch = 0; ch < 3; ch++) begin : g_ch
        bicubic_tap_filter #(
            .sample_t (h_sample_t),
            .acc_t    (v_sample_t)
        ) u_h_filter (
            .s0    (h_sample_t'({1'b0, pix0[ch*CH_W +: CH_W]})),
            .s1    (h_sample_t'({1'b0, pix1[ch*CH_W +: CH_W]})),
            .s2    (h_sample_t'({1'b0, pix2[ch*CH_W +: CH_W]})),
            .s3    (h_sample_t'({1'b0, pix3[ch*CH_W +: CH_W]})),
            .phase (h_phase),
            .acc   (h_cur[ch])
        );

        bicubic_tap_filter #(
            .sample_t (v_sample_t),
            .acc_t    (v_acc_t)
        ) u_v_filter (
            .s0    (h_hold[ch][0]),
            .s1    (h_hold[ch][1]),
            .s2    (h_hold[ch][2]),
            .s3    (h_cur[ch]),
            .phase (v_phase),
            .acc   (v_sum[ch])
        );

        assign ch_out[ch] = round_clamp(v_sum[ch]);
    end

    // horizontal results of row taps 0..2 wait here for tap 3
    always_ff @(posedge clk) begin
        if (tap_valid && (tap_idx != 2'd3)) begin
            for (int ch = 0; ch < 3; ch++) begin
                h_hold[ch][tap_idx] <= h_cur[ch];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= final_tap;
        end
    end

    always_ff @(posedge clk) begin
        if (final_tap) begin
            push_beat.data <= {ch_out[2], ch_out[1], ch_out[0]};
            push_beat.last <= tap_last;
        end
    end

    // each push closes a full four tap sequence from the sequencer
    a_push_after_taps: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !$past(push) && $past(tap_valid && (tap_idx == 2'd0), 4)
    );

endmodule

// File: logic/bicubic_output_fifo.sv
`timescale 1ns/1ps

module bicubic_output_fifo
    import bicubic_pkg::*;
#(
    parameter type item_t = out_beat_t
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  item_t  push_data,
    input  logic   pop_ready,
    output logic   pop_valid,
    output item_t  pop_data,
    output level_t level
);

    item_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  pop;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] p);
        if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // head entry shows straight on the output, zero while empty
    assign pop_valid = (level != '0);
    assign pop       = pop_valid && pop_ready;
    assign pop_data  = pop_valid ? mem[rd_ptr] : item_t'('0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // the sequencer's credit check keeps pushes away from a full FIFO
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (level < level_t'(FIFO_DEPTH)) || pop
    );

endmodule

// File: logic/bicubic_scaler_top.sv
`timescale 1ns/1ps

module bicubic_scaler_top
    import bicubic_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  pixel_t in_data,
    output logic   out_valid,
    input  logic   out_ready,
    output pixel_t out_data,
    output logic   out_last
);

    logic      wr_en;
    src_addr_t wr_addr;
    logic      rd_en;
    row_t      rd_row;
    col_t      rd_col;
    pixel_t    rd_pix0;
    pixel_t    rd_pix1;
    pixel_t    rd_pix2;
    pixel_t    rd_pix3;
    logic      tap_valid;
    tap_idx_t  tap_idx;
    logic      h_phase;
    logic      v_phase;
    logic      tap_last;
    logic      push;
    out_beat_t push_beat;
    out_beat_t pop_beat;
    level_t    level;

    bicubic_addr_gen u_addr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .level     (level),
        .in_ready  (in_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .rd_en     (rd_en),
        .rd_row    (rd_row),
        .rd_col    (rd_col),
        .tap_valid (tap_valid),
        .tap_idx   (tap_idx),
        .h_phase   (h_phase),
        .v_phase   (v_phase),
        .tap_last  (tap_last)
    );

    // input pixels go straight into the buffer
    bicubic_frame_buffer u_frame_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (in_data),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_pix0 (rd_pix0),
        .rd_pix1 (rd_pix1),
        .rd_pix2 (rd_pix2),
        .rd_pix3 (rd_pix3)
    );

    bicubic_kernel u_kernel (
        .clk       (clk),
        .rst_n     (rst_n),
        .tap_valid (tap_valid),
        .tap_idx   (tap_idx),
        .h_phase   (h_phase),
        .v_phase   (v_phase),
        .tap_last  (tap_last),
        .pix0      (rd_pix0),
        .pix1      (rd_pix1),
        .pix2      (rd_pix2),
        .pix3      (rd_pix3),
        .push      (push),
        .push_beat (push_beat)
    );

    bicubic_output_fifo #(
        .item_t (out_beat_t)
    ) u_output_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_beat),
        .pop_ready (out_ready),
        .pop_valid (out_valid),
        .pop_data  (pop_beat),
        .level     (level)
    );

    assign out_data = pop_beat.data;
    assign out_last = pop_beat.last;

endmodule

// File: sim/bicubic_pixel_source.sv
`timescale 1ns/1ps

module bicubic_pixel_source
    import bicubic_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ready,
    output logic   valid = 1'b0,
    output pixel_t data = '0
);

    localparam int FRAMES = 2;

    pixel_t img [SRC_PIX];
    int     sent;

    initial begin
        $readmemh("sim/src_image.hex", img);
    end

    // valid is withheld about one cycle in four, once raised it holds until taken
    always @(posedge clk or negedge rst_n) begin : drive
        int next_sent;
        if (!rst_n) begin
            valid <= 1'b0;
            data  <= '0;
            sent  <= 0;
        end else begin
            next_sent = sent;
            if (valid && ready) begin
                next_sent = sent + 1;
            end
            if (!valid || ready) begin
                if ((next_sent < FRAMES * SRC_PIX) && (($urandom % 4) != 0)) begin
                    valid <= 1'b1;
                    // same frame again after the first one
                    data  <= img[next_sent % SRC_PIX];
                end else begin
                    valid <= 1'b0;
                end
            end
            sent <= next_sent;
        end
    end

endmodule

// File: sim/tb_bicubic_scaler.sv
`timescale 1ns/1ps

module tb_bicubic_scaler
    import bicubic_pkg::*;
();

    localparam int OUT_PIX      = OUT_W * OUT_H;
    localparam int RESET_CYCLES = 16;
    // two frames of taps and loads, four times over for random stalls
    localparam int TIMEOUT      = 2 * (OUT_PIX * 4 + SRC_PIX) * 4 + RESET_CYCLES;

    logic   clk = 1'b0;
    logic   rst_n = 1'b0;
    logic   in_valid;
    logic   in_ready;
    pixel_t in_data;
    logic   out_valid;
    logic   out_ready = 1'b0;
    pixel_t out_data;
    logic   out_last;

    int     errs [1:6] = '{default: 0};
    int     checks;
    int     beat;
    int     frames_done;
    int     in_cnt;
    int     reset_seen;
    int     cycles;
    int     total_errs;
    bit     loading = 1'b1;
    bit     frame_done;
    bit     hold_valid;
    pixel_t hold_data;
    logic   hold_last;

    bicubic_pixel_source u_pixel_source (
        .clk   (clk),
        .rst_n (rst_n),
        .ready (in_ready),
        .valid (in_valid),
        .data  (in_data)
    );

    bicubic_scaler_top u_bicubic_scaler_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        out_ready <= ($urandom % 4) != 0;
    end

    function automatic int clamp_index(input int i, input int hi);
        return (i < 0) ? 0 : ((i > hi) ? hi : i);
    endfunction

    // row sums at full precision, then the column sum, round and saturate
    function automatic pixel_t ref_pixel(input int ox, input int oy);
        int     hsum [4];
        int     vsum;
        int     row;
        int     col;
        pixel_t res;
        res = '0;
        for (int ch = 0; ch < 3; ch++) begin
            vsum = 0;
            for (int r = 0; r < 4; r++) begin
                row = clamp_index(oy / 2 - 1 + r, IMG_H - 1);
                hsum[r] = 0;
                for (int t = 0; t < 4; t++) begin
                    col = clamp_index(ox / 2 - 1 + t, IMG_W - 1);
                    hsum[r] += int'(WEIGHTS[ox % 2][t])
                        * int'(u_pixel_source.img[row * IMG_W + col][ch * CH_W +: CH_W]);
                end
                vsum += int'(WEIGHTS[oy % 2][r]) * hsum[r];
            end
            vsum = (vsum + (1 << (2 * W_FRAC - 1))) >>> (2 * W_FRAC);
            vsum = (vsum < 0) ? 0 : ((vsum > 255) ? 255 : vsum);
            res[ch * CH_W +: CH_W] = vsum[CH_W-1:0];
        end
        return res;
    endfunction

    task automatic value_error(input int test, input string sig,
                               input logic [PIX_W-1:0] expv, input logic [PIX_W-1:0] actv);
        $display("ERROR %s beat %0d frame %0d: expected %h, got %h",
                 sig, beat, frames_done, expv, actv);
        errs[test]++;
    endtask

    task automatic fault(input int test, input string what);
        $display("at %0t ns: %s", $time, what);
        errs[test]++;
    endtask

    task automatic report_test(input int test, input string name);
        if (errs[test] == 0) begin
            $display("test %0d %s: ok", test, name);
        end else begin
            $display("test %0d %s: %0d errors", test, name, errs[test]);
        end
    endtask

    always @(posedge clk) begin : compare
        pixel_t exp_pix;
        int     ox;
        int     oy;
        if (!rst_n) begin
            // the DUT reset lands on the first edge
            if (reset_seen > 0) begin
                checks++;
                if (in_ready !== 1'b1 || out_valid !== 1'b0 || out_last !== 1'b0) begin
                    fault(1, "in_ready, out_valid or out_last wrong during reset");
                end
            end
            reset_seen++;
        end else begin
            checks += 2;
            if (!out_valid && out_last !== 1'b0) begin
                fault(1, "out_last high while out_valid is low");
            end
            if (loading && in_ready !== 1'b1) begin
                fault(6, "in_ready low while a frame is loading");
            end
            if (!loading && in_ready === 1'b1) begin
                if (!frame_done) begin
                    fault(6, "in_ready rose before the output frame drained");
                end
                loading = 1'b1;
                frame_done = 1'b0;
            end
            if (in_valid && in_ready) begin
                in_cnt++;
                if (in_cnt == SRC_PIX) begin
                    in_cnt = 0;
                    loading = 1'b0;
                end
            end
            // a waiting beat must stay put
            if (hold_valid) begin
                checks++;
                if (out_valid !== 1'b1) begin
                    fault(5, "out_valid dropped before the beat was taken");
                end else if (out_data !== hold_data) begin
                    value_error(5, "out_data", hold_data, out_data);
                end else if (out_last !== hold_last) begin
                    value_error(5, "out_last", hold_last, out_last);
                end
            end
            hold_valid = out_valid && !out_ready;
            hold_data  = out_data;
            hold_last  = out_last;
            if (frames_done >= 2 && out_valid === 1'b1) begin
                fault(4, "output beat after the final frame");
            end
            if (out_valid === 1'b1 && out_ready) begin
                ox = beat % OUT_W;
                oy = beat / OUT_W;
                exp_pix = ref_pixel(ox, oy);
                checks += 2;
                // the repeated frame must give the same reference pixels again
                if (out_data !== exp_pix) begin
                    value_error((frames_done == 0) ? 3 : 6, "out_data", exp_pix, out_data);
                end
                if ((ox % 2 == 0) && (oy % 2 == 0)) begin
                    checks++;
                    if (out_data !== u_pixel_source.img[(oy / 2) * IMG_W + ox / 2]) begin
                        value_error(2, "out_data",
                                    u_pixel_source.img[(oy / 2) * IMG_W + ox / 2], out_data);
                    end
                end
                if (out_last !== (beat == OUT_PIX - 1)) begin
                    value_error(4, "out_last", beat == OUT_PIX - 1, out_last);
                end
                beat++;
                if (beat == OUT_PIX) begin
                    beat = 0;
                    frames_done++;
                    frame_done = 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h9eeb5889));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // both frames out and the DUT back in load
        while ((frames_done < 2 || !loading) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        report_test(1, "reset and idle outputs");
        report_test(2, "even positions copy the source");
        report_test(3, "every pixel matches the reference");
        report_test(4, "out_last and beats per frame");
        report_test(5, "beats hold under out_ready stalls");
        report_test(6, "reload and repeated frame");
        foreach (errs[i]) begin
            total_errs += errs[i];
        end
        $display("checks: %0d, errors: %0d, frames: %0d, cycles: %0d",
                 checks, total_errs, frames_done, cycles);
        if (frames_done < 2 || !loading) begin
            $display("run stopped at the cycle limit with %0d of 2 frames received", frames_done);
            $display("Simulation failed");
        end else if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/src_image.hex
// one source pixel per line as rrggbb (blue in the low byte)
// row-major, 6 columns by 4 rows
ff0000
00ff00
0000ff
ffffff
000000
808080
102030
f0e0d0
00ff80
7f7f7f
ff00ff
204060
000000
ffffff
000000
ffffff
123456
abcdef
55aa55
aa55aa
0f0f0f
f0f0f0
c0ffee
01fe02

// File: flist.f
logic/bicubic_pkg.sv
logic/bicubic_frame_buffer.sv
logic/bicubic_addr_gen.sv
logic/bicubic_tap_filter.sv
logic/bicubic_kernel.sv
logic/bicubic_output_fifo.sv
logic/bicubic_scaler_top.sv
sim/bicubic_pixel_source.sv
sim/tb_bicubic_scaler.sv

// File: Bender.yml
package:
  name: bicubic_scaler

sources:
  - files:
      - logic/bicubic_pkg.sv
      - logic/bicubic_frame_buffer.sv
      - logic/bicubic_addr_gen.sv
      - logic/bicubic_tap_filter.sv
      - logic/bicubic_kernel.sv
      - logic/bicubic_output_fifo.sv
      - logic/bicubic_scaler_top.sv
  - target: simulation
    files:
      - sim/bicubic_pixel_source.sv
      - sim/tb_bicubic_scaler.sv
